/* vlog.f */
rtl/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_memwb.sv
rtl/rv_hazard.sv
rtl/rv_core.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_core.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it and checks the log

set -o pipefail
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_core -o tb_core_sim \
    && ./obj_dir/tb_core_sim | tee "$log" \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -qx "ALL CHECKS PASSED" "$log" && echo "Result: pass" || { echo "Result: fail"; exit 1; }

/* tests/tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core import rv_pkg::*; ();

    localparam word_t RESET_PC     = 32'h0000_0100;
    localparam int    PROG_LEN     = 25;
    localparam int    CLK_NS       = 20;
    localparam int    RESET_CYCLES = 4;
    localparam int    DRAIN_CYCLES = 8;
    localparam int    WATCHDOG_NS  = PROG_LEN * 10 * CLK_NS + RESET_CYCLES * CLK_NS;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef struct packed {
        word_t     instr;
        logic      writes;
        reg_addr_t rd;
        word_t     value;
    } prog_row_t;

    logic      clk;
    logic      arst_n;
    word_t     imem_addr;
    word_t     imem_rdata;
    retire_t   retire;
    prog_row_t prog [PROG_LEN];
    word_t     rom [PROG_LEN];
    retire_t   exp_list [PROG_LEN];
    int        exp_count;
    int        row_count;
    int        errors;
    int        checked;
    int        pending;

    function automatic word_t rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input reg_addr_t rd, input reg_addr_t rs1,
                                         input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t itype_word(input logic [6:0] opc, input logic [2:0] f3,
                                         input reg_addr_t rd, input reg_addr_t rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t stype_word(input reg_addr_t rs1, input reg_addr_t rs2,
                                         input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    // Branch offset is 13 bits with bit 0 always zero
    function automatic word_t btype_word(input logic [2:0] f3, input reg_addr_t rs1,
                                         input reg_addr_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t jtype_word(input reg_addr_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // Addresses outside the program read as NOP
    function automatic word_t rom_word(input word_t addr);
        int idx;
        idx = int'((addr - RESET_PC) >> 2);
        if (idx >= 0 && idx < PROG_LEN) begin
            return rom[idx];
        end
        return NOP_INSTR;
    endfunction

    task automatic add_row(input word_t instr, input logic writes, input reg_addr_t rd,
                           input word_t value);
        prog[row_count] = '{instr: instr, writes: writes, rd: rd, value: value};
        row_count++;
    endtask

    task automatic load_program();
        // Dependent ALU chain over both bypass paths
        add_row(itype_word(OPC_IMM, F3_ADD, 5'd1, 5'd0, 12'd12), 1'b1, 5'd1, 32'h0000_000c);
        add_row(itype_word(OPC_IMM, F3_ADD, 5'd2, 5'd0, 12'd10), 1'b1, 5'd2, 32'h0000_000a);
        add_row(rtype_word(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 32'h0000_0016);
        add_row(rtype_word(F7_SUB, F3_ADD, 5'd4, 5'd1, 5'd3), 1'b1, 5'd4, 32'hffff_fff6);
        add_row(rtype_word(F7_BASE, F3_AND, 5'd5, 5'd4, 5'd3), 1'b1, 5'd5, 32'h0000_0016);
        add_row(rtype_word(F7_BASE, F3_OR, 5'd6, 5'd5, 5'd1), 1'b1, 5'd6, 32'h0000_001e);
        add_row(rtype_word(F7_BASE, F3_XOR, 5'd7, 5'd6, 5'd4), 1'b1, 5'd7, 32'hffff_ffe8);
        add_row(rtype_word(F7_BASE, F3_SLT, 5'd8, 5'd7, 5'd6), 1'b1, 5'd8, 32'h0000_0001);
        // Store then load back and use at once
        add_row(stype_word(5'd0, 5'd7, 12'd8), 1'b0, 5'd0, 32'h0);
        add_row(itype_word(OPC_LOAD, F3_WORD, 5'd9, 5'd0, 12'd8), 1'b1, 5'd9, 32'hffff_ffe8);
        add_row(rtype_word(F7_BASE, F3_ADD, 5'd10, 5'd9, 5'd1), 1'b1, 5'd10, 32'hffff_fff4);
        add_row(itype_word(OPC_IMM, F3_ADD, 5'd0, 5'd0, 12'd7), 1'b0, 5'd0, 32'h0);
        add_row(rtype_word(F7_BASE, F3_ADD, 5'd11, 5'd0, 5'd1), 1'b1, 5'd11, 32'h0000_000c);
        // Taken BEQ skips two
        add_row(btype_word(F3_BEQ, 5'd1, 5'd1, 13'd12), 1'b0, 5'd0, 32'h0);
        add_row(itype_word(OPC_IMM, F3_ADD, 5'd12, 5'd0, 12'd1), 1'b0, 5'd0, 32'h0);
        add_row(itype_word(OPC_IMM, F3_ADD, 5'd13, 5'd0, 12'd2), 1'b0, 5'd0, 32'h0);
        add_row(btype_word(F3_BNE, 5'd1, 5'd1, 13'd8), 1'b0, 5'd0, 32'h0);
        add_row(itype_word(OPC_IMM, F3_ADD, 5'd15, 5'd0, 12'h066), 1'b1, 5'd15, 32'h0000_0066);
        add_row(itype_word(OPC_IMM, F3_ADD, 5'd14, 5'd0, 12'h055), 1'b1, 5'd14, 32'h0000_0055);
        // JAL at offset 0x4c links offset 0x50
        add_row(jtype_word(5'd16, 21'd12), 1'b1, 5'd16, RESET_PC + 32'h0000_0050);
        add_row(itype_word(OPC_IMM, F3_ADD, 5'd17, 5'd0, 12'd1), 1'b0, 5'd0, 32'h0);
        add_row(itype_word(OPC_IMM, F3_ADD, 5'd18, 5'd0, 12'd2), 1'b0, 5'd0, 32'h0);
        add_row(itype_word(OPC_IMM, F3_ADD, 5'd19, 5'd0, 12'h077), 1'b1, 5'd19, 32'h0000_0077);
        add_row(itype_word(OPC_IMM, F3_ADD, 5'd20, 5'd16, 12'd1), 1'b1, 5'd20,
                RESET_PC + 32'h0000_0051);
        add_row(btype_word(F3_BEQ, 5'd0, 5'd0, 13'd0), 1'b0, 5'd0, 32'h0); // Park here
    endtask

    tb_clock #(
        .HALF_NS(CLK_NS / 2),
        .RESET_CYCLES(RESET_CYCLES)
    ) u_clock (
        .clk_o(clk),
        .arst_n_o(arst_n)
    );

    rv_core #(
        .RESET_PC(RESET_PC),
        .DMEM_WORDS(64)
    ) u_dut (
        .clk(clk),
        .arst_n_i(arst_n),
        .imem_addr_o(imem_addr),
        .imem_rdata_i(imem_rdata),
        .retire_o(retire)
    );

    tb_checker #(
        .RESET_PC(RESET_PC),
        .MAX_EXP(PROG_LEN)
    ) u_check (
        .clk_i(clk),
        .arst_n_i(arst_n),
        .imem_addr_i(imem_addr),
        .retire_i(retire),
        .exp_i(exp_list),
        .exp_count_i(exp_count),
        .errors_o(errors),
        .checked_o(checked),
        .pending_o(pending)
    );

    // Instruction ROM answers within the cycle
    initial begin
        imem_rdata = NOP_INSTR;
        forever begin
            @(posedge clk);
            #1;
            imem_rdata = rom_word(imem_addr);
        end
    end

    initial begin
        row_count = 0;
        exp_count = 0;
        load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            rom[i] = prog[i].instr;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            if (prog[i].writes) begin
                exp_list[exp_count] = '{valid: 1'b1, rd: prog[i].rd, data: prog[i].value};
                exp_count++;
            end
        end
        @(posedge arst_n);
        wait (pending == 0);
        repeat (DRAIN_CYCLES) @(posedge clk); // Room for any stray retire
        $display("Writes checked %0d, errors %0d", checked, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns with %0d expected writes never retired",
                 WATCHDOG_NS, pending);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker import rv_pkg::*; #(
    parameter word_t RESET_PC = '0,
    parameter int    MAX_EXP  = 32
) (
    input  wire     clk_i,
    input  wire     arst_n_i,
    input  word_t   imem_addr_i,
    input  retire_t retire_i,
    input  retire_t exp_i [MAX_EXP],
    input  int      exp_count_i,
    output int      errors_o,
    output int      checked_o,
    output int      pending_o
);

    retire_t exp_q [$];
    retire_t exp_w;
    logic    fetch_seen;

    // Sampled mid-cycle, well away from the DUT's edge
    always @(negedge clk_i) begin
        if (!arst_n_i) begin
            exp_q.delete(); // Reloaded on every reset cycle
            for (int i = 0; i < exp_count_i; i++) begin
                exp_q.push_back(exp_i[i]);
            end
            fetch_seen = 1'b0;
        end
        if (!fetch_seen) begin
            if (imem_addr_i !== RESET_PC) begin
                $display("[ERROR] %0t imem_addr_o expected %h got %h",
                         $time, RESET_PC, imem_addr_i);
                errors_o++;
            end
            fetch_seen = arst_n_i; // First fetch after reset is checked too
        end
        if (retire_i.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected retire at %0t ns, x%0d written with %h",
                         $time, retire_i.rd, retire_i.data);
                errors_o++;
            end else begin
                exp_w = exp_q.pop_front();
                if (retire_i.rd !== exp_w.rd) begin
                    $display("[ERROR] %0t retire_o.rd expected %0d got %0d",
                             $time, exp_w.rd, retire_i.rd);
                    errors_o++;
                end
                if (retire_i.data !== exp_w.data) begin
                    $display("[ERROR] %0t retire_o.data expected %h got %h",
                             $time, exp_w.data, retire_i.data);
                    errors_o++;
                end
                checked_o++;
            end
        end else if (retire_i.valid !== 1'b0) begin
            $display("retire_o.valid is unknown at %0t ns", $time);
            errors_o++;
        end
        pending_o = exp_q.size();
    end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_NS      = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_NS) clk_o = ~clk_o;
    end

    // Release lands just after an edge, like every other input
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; #(
    parameter word_t RESET_PC   = '0,
    parameter int    DMEM_WORDS = 64
) (
    input  wire     clk,
    input  wire     arst_n_i,
    output word_t   imem_addr_o,
    input  word_t   imem_rdata_i,
    output retire_t retire_o
);

    word_t     id_pc;
    word_t     id_instr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      uses_rs2;
    logic      ex_mem_read;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    logic      stall;
    logic      flush;
    logic      redirect;
    word_t     target;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;

    rv_fetch #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .stall_i(stall),
        .flush_i(flush),
        .redirect_i(redirect),
        .target_i(target),
        .instr_i(imem_rdata_i),
        .pc_o(imem_addr_o),
        .id_pc_o(id_pc),
        .id_instr_o(id_instr)
    );

    rv_decode u_decode (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .stall_i(stall),
        .flush_i(flush),
        .pc_i(id_pc),
        .instr_i(id_instr),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .rs1_addr_o(rs1_addr),
        .rs2_addr_o(rs2_addr),
        .uses_rs2_o(uses_rs2),
        .mem_read_o(ex_mem_read),
        .ex_o(id_ex)
    );

    rv_regfile u_regfile (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .rs1_addr_i(rs1_addr),
        .rs2_addr_i(rs2_addr),
        .wb_i(mem_wb),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data)
    );

    rv_hazard u_hazard (
        .id_rs1_i(rs1_addr),
        .id_rs2_i(rs2_addr),
        .id_uses_rs2_i(uses_rs2),
        .ex_rd_i(id_ex.rd),
        .ex_mem_read_i(ex_mem_read),
        .ex_rs1_i(id_ex.rs1),
        .ex_rs2_i(id_ex.rs2),
        .mem_i(ex_mem),
        .wb_i(mem_wb),
        .redirect_i(redirect),
        .stall_o(stall),
        .flush_o(flush),
        .fwd_a_o(fwd_a),
        .fwd_b_o(fwd_b)
    );

    rv_execute u_execute (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .ex_i(id_ex),
        .fwd_a_i(fwd_a),
        .fwd_b_i(fwd_b),
        .mem_result_i(ex_mem.result),
        .wb_i(mem_wb),
        .redirect_o(redirect),
        .target_o(target),
        .mem_o(ex_mem)
    );

    rv_memwb #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_memwb (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .mem_i(ex_mem),
        .wb_o(mem_wb),
        .retire_o(retire_o)
    );

endmodule

`default_nettype wire

/* rtl/rv_hazard.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_hazard import rv_pkg::*; (
    input  reg_addr_t id_rs1_i,
    input  reg_addr_t id_rs2_i,
    input  wire       id_uses_rs2_i,
    input  reg_addr_t ex_rd_i,
    input  wire       ex_mem_read_i,
    input  reg_addr_t ex_rs1_i,
    input  reg_addr_t ex_rs2_i,
    input  ex_mem_t   mem_i,
    input  mem_wb_t   wb_i,
    input  wire       redirect_i,
    output logic      stall_o,
    output logic      flush_o,
    output fwd_sel_e  fwd_a_o,
    output fwd_sel_e  fwd_b_o
);

    // Younger MEM result wins over WB
    function automatic fwd_sel_e fwd_pick(input reg_addr_t src, input ex_mem_t m,
                                          input mem_wb_t w);
        if (src == '0) begin
            fwd_pick = FWD_NONE;
        end else if (m.reg_write && (m.rd == src)) begin
            fwd_pick = FWD_FROM_MEM;
        end else if (w.reg_write && (w.rd == src)) begin
            fwd_pick = FWD_FROM_WB;
        end else begin
            fwd_pick = FWD_NONE;
        end
    endfunction

    // Load result not ready until WB, hold decode one cycle
    assign stall_o = ex_mem_read_i && (ex_rd_i != '0)
                     && ((ex_rd_i == id_rs1_i) || (id_uses_rs2_i && (ex_rd_i == id_rs2_i)));

    assign flush_o = redirect_i;

    assign fwd_a_o = fwd_pick(ex_rs1_i, mem_i, wb_i);
    assign fwd_b_o = fwd_pick(ex_rs2_i, mem_i, wb_i);

endmodule

`default_nettype wire

/* rtl/rv_memwb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_memwb import rv_pkg::*; #(
    parameter int DMEM_WORDS = 64
) (
    input  wire     clk,
    input  wire     arst_n_i,
    input  ex_mem_t mem_i,
    output mem_wb_t wb_o,
    output retire_t retire_o
);

    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    word_t              dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    word_t              load_data;
    mem_wb_t            nxt;

    assign word_idx  = mem_i.result[DMEM_AW+1:2]; // Word address, byte offset ignored
    assign load_data = dmem[word_idx];

    always_ff @(posedge clk) begin
        if (mem_i.mem_write) begin
            dmem[word_idx] <= mem_i.store_data;
        end
    end

    always_comb begin
        nxt.data      = mem_i.mem_read ? load_data : mem_i.result;
        nxt.rd        = mem_i.rd;
        nxt.reg_write = mem_i.reg_write;
    end

    // MEM/WB register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_o <= '0;
        end else begin
            wb_o <= nxt;
        end
    end

    // Writes to x0 are not reported
    assign retire_o.valid = wb_o.reg_write && (wb_o.rd != '0);
    assign retire_o.rd    = wb_o.rd;
    assign retire_o.data  = wb_o.data;

endmodule

`default_nettype wire

/* rtl/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_pkg::*; (
    input  wire      clk,
    input  wire      arst_n_i,
    input  id_ex_t   ex_i,
    input  fwd_sel_e fwd_a_i,
    input  fwd_sel_e fwd_b_i,
    input  word_t    mem_result_i,
    input  mem_wb_t  wb_i,
    output logic     redirect_o,
    output word_t    target_o,
    output ex_mem_t  mem_o
);

    word_t   op_a;
    word_t   op_b;
    word_t   alu_b;
    word_t   alu_res;
    logic    taken;
    ex_mem_t nxt;

    // Operand bypass
    always_comb begin
        case (fwd_a_i)
            FWD_FROM_MEM: op_a = mem_result_i;
            FWD_FROM_WB:  op_a = wb_i.data;
            default:      op_a = ex_i.rs1_data;
        endcase
        case (fwd_b_i)
            FWD_FROM_MEM: op_b = mem_result_i;
            FWD_FROM_WB:  op_b = wb_i.data;
            default:      op_b = ex_i.rs2_data;
        endcase
    end

    assign alu_b = ex_i.ctrl.alu_src_imm ? ex_i.imm : op_b;

    always_comb begin
        case (ex_i.ctrl.alu_op)
            ALU_SUB: alu_res = op_a - alu_b;
            ALU_AND: alu_res = op_a & alu_b;
            ALU_OR:  alu_res = op_a | alu_b;
            ALU_XOR: alu_res = op_a ^ alu_b;
            ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(alu_b)};
            default: alu_res = op_a + alu_b;
        endcase
    end

    // BEQ or BNE, resolved here
    assign taken      = ex_i.ctrl.is_branch && ((op_a == op_b) ^ ex_i.ctrl.branch_ne);
    assign redirect_o = taken || ex_i.ctrl.is_jal;
    assign target_o   = ex_i.pc + ex_i.imm;

    always_comb begin
        nxt.result     = ex_i.ctrl.is_jal ? ex_i.pc + 32'd4 : alu_res; // Link value
        nxt.store_data = op_b;
        nxt.rd         = ex_i.rd;
        nxt.mem_read   = ex_i.ctrl.mem_read;
        nxt.mem_write  = ex_i.ctrl.mem_write;
        nxt.reg_write  = ex_i.ctrl.reg_write;
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_o <= '0;
        end else begin
            mem_o <= nxt;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
    input  wire       clk,
    input  wire       arst_n_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  mem_wb_t   wb_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o
);

    word_t regs [32];
    logic  wr_en;

    assign wr_en = wb_i.reg_write && (wb_i.rd != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // Same-cycle write is visible to the reader
    assign rs1_data_o = (rs1_addr_i == '0)                      ? '0        :
                        (wr_en && (wb_i.rd == rs1_addr_i))      ? wb_i.data :
                                                                  regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0)                      ? '0        :
                        (wr_en && (wb_i.rd == rs2_addr_i))      ? wb_i.data :
                                                                  regs[rs2_addr_i];

endmodule

`default_nettype wire

/* rtl/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_pkg::*; (
    input  wire       clk,
    input  wire       arst_n_i,
    input  wire       stall_i,
    input  wire       flush_i,
    input  word_t     pc_i,
    input  word_t     instr_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output logic      uses_rs2_o,
    output logic      mem_read_o,
    output id_ex_t    ex_o
);

    instr_u ins;
    word_t  imm_i;
    word_t  imm_s;
    word_t  imm_b;
    word_t  imm_j;
    word_t  imm;
    ctrl_t  ctrl;
    id_ex_t nxt;

    function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic sub);
        case (funct3)
            3'b000:  alu_decode = sub ? ALU_SUB : ALU_ADD;
            3'b010:  alu_decode = ALU_SLT;
            3'b100:  alu_decode = ALU_XOR;
            3'b110:  alu_decode = ALU_OR;
            3'b111:  alu_decode = ALU_AND;
            default: alu_decode = ALU_ADD;
        endcase
    endfunction

    assign ins = instr_i;

    assign rs1_addr_o = ins.r.rs1;
    assign rs2_addr_o = ins.r.rs2;
    assign uses_rs2_o = (ins.r.opcode == OPC_OP) || (ins.r.opcode == OPC_STORE)
                        || (ins.r.opcode == OPC_BRANCH);
    assign mem_read_o = ex_o.ctrl.mem_read; // Load now sitting in EX

    // Immediates, all sign extended
    assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
    assign imm_s = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
    assign imm_b = {{19{ins.bj.sign}}, ins.bj.sign, ins.bj.b_imm_11, ins.bj.imm_10_5,
                    ins.bj.b_imm_4_1, 1'b0};
    assign imm_j = {{11{ins.bj.sign}}, ins.bj.sign, ins.bj.j_imm_19_12, ins.bj.j_imm_11,
                    ins.bj.imm_10_5, ins.bj.j_imm_4_1, 1'b0};

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (ins.r.opcode)
            OPC_OP: begin
                ctrl.alu_op    = alu_decode(ins.r.funct3, ins.r.funct7[5]);
                ctrl.reg_write = 1'b1;
            end
            OPC_IMM: begin
                ctrl.alu_op      = alu_decode(ins.i.funct3, 1'b0);
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                imm              = imm_i;
            end
            OPC_LOAD: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.reg_write   = 1'b1;
                imm              = imm_i;
            end
            OPC_STORE: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
                imm              = imm_s;
            end
            OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = ins.r.funct3[0]; // BNE is funct3 001
                imm            = imm_b;
            end
            OPC_JAL: begin
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_j;
            end
            default: ; // Unsupported opcodes become bubbles
        endcase
    end

    always_comb begin
        nxt.pc       = pc_i;
        nxt.rs1_data = rs1_data_i;
        nxt.rs2_data = rs2_data_i;
        nxt.rs1      = ins.r.rs1;
        nxt.rs2      = ins.r.rs2;
        nxt.rd       = ins.r.rd;
        nxt.imm      = imm;
        nxt.ctrl     = (stall_i || flush_i) ? '0 : ctrl;
    end

    // ID/EX register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_o <= '0;
        end else begin
            ex_o <= nxt;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch import rv_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  wire   clk,
    input  wire   arst_n_i,
    input  wire   stall_i,
    input  wire   flush_i,
    input  wire   redirect_i,
    input  word_t target_i,
    input  word_t instr_i,
    output word_t pc_o,
    output word_t id_pc_o,
    output word_t id_instr_o
);

    word_t pc_q;

    assign pc_o = pc_q;

    // Redirect wins over a stall
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= target_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // IF/ID register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_pc_o    <= '0;
            id_instr_o <= NOP_INSTR;
        end else if (flush_i) begin
            id_instr_o <= NOP_INSTR; // Wrong-path fetch dropped
        end else if (!stall_i) begin
            id_pc_o    <= pc_q;
            id_instr_o <= instr_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam word_t NOP_INSTR = 32'h0000_0013; // ADDI x0, x0, 0

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    // Immediate bits of both B and J formats, sign bit shared
    typedef struct packed {
        logic       sign;
        logic [5:0] imm_10_5;
        logic [3:0] j_imm_4_1;
        logic       j_imm_11;
        logic [7:0] j_imm_19_12;
        logic [3:0] b_imm_4_1;
        logic       b_imm_11;
        logic [6:0] opcode;
    } bj_type_t;

    typedef union packed {
        r_type_t  r;
        i_type_t  i;
        s_type_t  s;
        bj_type_t bj;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // All-zero value is a bubble
    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jal;
    } ctrl_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        ctrl_t     ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
    } ex_mem_t;

    typedef struct packed {
        word_t     data;
        reg_addr_t rd;
        logic      reg_write;
    } mem_wb_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_FROM_MEM,
        FWD_FROM_WB
    } fwd_sel_e;

endpackage

`default_nettype wire
